// File: logic/odt_defs.svh
/*
 * ODT generator shared constants
 * sizes of the chip-select bus, the latency fields, the delay line and the ODT window
 */
`ifndef ODT_DEFS_SVH
`define ODT_DEFS_SVH

// number of chip selects and ODT lines in whole groups of four ranks
`define ODT_CS_WIDTH 4

// CAS latency field width in the mode register image
`define ODT_TCL_WIDTH 4

// additive latency field width
`define ODT_AL_WIDTH 3

// largest ODT start delay in controller cycles that the delay line can reach
`define ODT_MAX_DELAY 15

// the ODT window covers four data cycles of a BL8 burst plus two guard cycles
`define ODT_HOLD_CYCLES 6

`endif

// File: logic/odt_pkg.sv
/*
 * ODT generator package
 * vector types for masks and latencies, plus the command word passed from
 * the control block into the rank map
 */
`include "odt_defs.svh"

package odt_pkg;

    // one bit per chip select, bit i drives ODT line i
    typedef logic [`ODT_CS_WIDTH-1:0] cs_mask_t;

    // programmed CAS latency in memory clocks
    typedef logic [`ODT_TCL_WIDTH-1:0] tcl_t;

    // programmed additive latency in memory clocks
    typedef logic [`ODT_AL_WIDTH-1:0] al_t;

    // ODT start delay in controller cycles
    // four bits covers the full 0 to 15 clamp range
    typedef logic [3:0] odt_delay_t;

    // registered command as seen by the rank map
    // only one of the two strobes is ever set
    typedef struct packed
    {
        logic     is_write;
        logic     is_read;
        cs_mask_t chips;
    } odt_cmd_t;

endpackage

// File: logic/odt_ctrl.sv
/*
 * ODT control block
 * samples the read/write strobes and chip mask, drops them while disabled,
 * and derives the clamped ODT start delay from CAS and additive latency
 */
`timescale 1ns/10ps
`include "odt_defs.svh"

module odt_ctrl
(
    input  logic               ctl_clk,
    input  logic               ctl_reset_n,
    input  logic               do_write,
    input  logic               do_read,
    input  odt_pkg::cs_mask_t  to_chip,
    input  odt_pkg::tcl_t      mem_tcl,
    input  odt_pkg::al_t       mem_add_lat,
    input  logic               odt_enable,
    output odt_pkg::odt_cmd_t  cmd,
    output odt_pkg::odt_delay_t delay
);
    import odt_pkg::*;

    // the latency sum needs one bit more than the wider of the two fields
    localparam int SUM_W = ((`ODT_TCL_WIDTH > `ODT_AL_WIDTH) ?
                            `ODT_TCL_WIDTH : `ODT_AL_WIDTH) + 1;

    logic [SUM_W-1:0] lat_sum;
    odt_delay_t       delay_next;

    // read latency seen at the pins is AL + CL
    // the ODT path already spends three cycles in its own registers
    assign lat_sum = SUM_W'(mem_tcl) + SUM_W'(mem_add_lat);

    always_comb
    begin
        if (lat_sum < SUM_W'(3))
        begin
            // a latency shorter than the pipeline starts the window as early as possible
            delay_next = '0;
        end
        else if ((lat_sum - SUM_W'(3)) > SUM_W'(`ODT_MAX_DELAY))
        begin
            delay_next = odt_delay_t'(`ODT_MAX_DELAY);
        end
        else
        begin
            delay_next = odt_delay_t'(lat_sum - SUM_W'(3));
        end
    end

    // a disabled controller registers an idle command in place of the strobes
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            cmd <= '0;
        end
        else if (odt_enable)
        begin
            cmd.is_write <= do_write;
            cmd.is_read  <= do_read;
            cmd.chips    <= to_chip;
        end
        else
        begin
            cmd <= '0;
        end
    end

    // the delay is registered so that the tap mux sees a plain flop select
    // latency inputs are quasi-static, so the extra cycle here costs nothing
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            delay <= '0;
        end
        else
        begin
            delay <= delay_next;
        end
    end

endmodule

// File: logic/odt_rank_map.sv
/*
 * ODT rank map
 * turns the addressed chips of a command into the chips that terminate,
 * using the two-ranks-per-DIMM partner scheme within each group of four
 */
`timescale 1ns/10ps
`include "odt_defs.svh"

module odt_rank_map
(
    input  odt_pkg::odt_cmd_t cmd,
    output odt_pkg::cs_mask_t term
);
    import odt_pkg::*;

    cs_mask_t partner;

    // chip j of a group pairs with chip j xor 2, i.e. the same rank on the other DIMM
    always_comb
    begin
        partner = '0;
        for (int g = 0; g < `ODT_CS_WIDTH / 4; g++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                partner[(g * 4) + (j ^ 2)] = cmd.chips[(g * 4) + j];
            end
        end
    end

    always_comb
    begin
        if (cmd.is_write)
        begin
            // the target DIMM terminates its own write as well as the idle DIMM
            term = cmd.chips | partner;
        end
        else if (cmd.is_read)
        begin
            // the driving rank must stay unterminated, only the other DIMM terminates
            term = partner;
        end
        else
        begin
            term = '0;
        end
    end

endmodule

// File: logic/odt_delay_line.sv
/*
 * ODT delay line
 * shifts the terminate mask of every command one stage per cycle and
 * taps out the stage picked by the programmed start delay
 */
`timescale 1ns/10ps
`include "odt_defs.svh"

module odt_delay_line
#(
    parameter int DEPTH = `ODT_MAX_DELAY + 1
)
(
    input  logic                ctl_clk,
    input  logic                ctl_reset_n,
    input  odt_pkg::cs_mask_t   term,
    input  odt_pkg::odt_delay_t delay,
    output odt_pkg::cs_mask_t   fire
);
    import odt_pkg::*;

    // stage i holds the mask that entered i cycles ago
    cs_mask_t stage [DEPTH];

    // every stage moves each cycle, so back-to-back commands never merge
    // and each one reaches the tap on its own cycle
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                stage[i] <= '0;
            end
        end
        else
        begin
            stage[0] <= term;
            for (int i = 1; i < DEPTH; i++)
            begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // output tap
    // a delay beyond the built depth gives no fire at all
    always_comb
    begin
        if (int'(delay) < DEPTH)
        begin
            fire = stage[delay];
        end
        else
        begin
            fire = '0;
        end
    end

endmodule

// File: logic/odt_hold_timer.sv
/*
 * ODT hold timer
 * one retriggerable down-counter per chip select that stretches each
 * fire pulse into an ODT window of HOLD cycles
 */
`timescale 1ns/10ps
`include "odt_defs.svh"

module odt_hold_timer
#(
    parameter int HOLD = `ODT_HOLD_CYCLES
)
(
    input  logic              ctl_clk,
    input  logic              ctl_reset_n,
    input  odt_pkg::cs_mask_t fire,
    output odt_pkg::cs_mask_t afi_odt
);
    // counter must be able to hold the value HOLD itself
    localparam int CNT_W = $clog2(HOLD + 1);

    logic [CNT_W-1:0] cnt      [`ODT_CS_WIDTH];
    logic [CNT_W-1:0] cnt_next [`ODT_CS_WIDTH];

    // a fire reloads the full window, so a later hit on the same chip
    // pushes its window end out rather than adding a gap
    always_comb
    begin
        for (int i = 0; i < `ODT_CS_WIDTH; i++)
        begin
            if (fire[i])
            begin
                cnt_next[i] = CNT_W'(HOLD);
            end
            else if (cnt[i] != '0)
            begin
                cnt_next[i] = cnt[i] - 1'b1;
            end
            else
            begin
                cnt_next[i] = '0;
            end
        end
    end

    // ODT is a flop output and goes high on the same edge as the load
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            for (int i = 0; i < `ODT_CS_WIDTH; i++)
            begin
                cnt[i] <= '0;
            end
            afi_odt <= '0;
        end
        else
        begin
            for (int i = 0; i < `ODT_CS_WIDTH; i++)
            begin
                cnt[i]     <= cnt_next[i];
                afi_odt[i] <= (cnt_next[i] != '0);
            end
        end
    end

endmodule

// File: logic/odt_gen_top.sv
/*
 * ODT generator top level
 * full-rate, one ODT line per chip select
 * chain is control, rank map, delay line, hold timer
 */
`timescale 1ns/10ps

module odt_gen_top
(
    input  logic                ctl_clk,
    input  logic                ctl_reset_n,
    input  logic                do_write,
    input  logic                do_read,
    input  odt_pkg::cs_mask_t   to_chip,
    input  odt_pkg::tcl_t       mem_tcl,
    input  odt_pkg::al_t        mem_add_lat,
    input  logic                odt_enable,
    output odt_pkg::cs_mask_t   afi_odt
);
    import odt_pkg::*;

    // registered command, one cycle after the strobe
    odt_cmd_t   cmd;
    // clamped start delay for the tap select
    odt_delay_t delay;
    // chips to terminate for the registered command
    cs_mask_t   term;
    // mask leaving the delay line on the cycle its window opens
    cs_mask_t   fire;

    odt_ctrl odt_ctrl_inst
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .do_write    (do_write),
        .do_read     (do_read),
        .to_chip     (to_chip),
        .mem_tcl     (mem_tcl),
        .mem_add_lat (mem_add_lat),
        .odt_enable  (odt_enable),
        .cmd         (cmd),
        .delay       (delay)
    );

    odt_rank_map odt_rank_map_inst
    (
        .cmd  (cmd),
        .term (term)
    );

    odt_delay_line odt_delay_line_inst
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .term        (term),
        .delay       (delay),
        .fire        (fire)
    );

    odt_hold_timer odt_hold_timer_inst
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .fire        (fire),
        .afi_odt     (afi_odt)
    );

endmodule

// File: test/odt_gen_checker.sv
/*
 * ODT generator checker
 * bound into the top level, watches strobe exclusivity, reset state and window length
 */
`timescale 1ns/10ps
`include "odt_defs.svh"

module odt_gen_checker
(
    input logic              ctl_clk,
    input logic              ctl_reset_n,
    input logic              do_write,
    input logic              do_read,
    input odt_pkg::cs_mask_t afi_odt
);
    import odt_pkg::*;

    // the controller never issues a read and a write in the same cycle
    strobe_exclusive: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n) !(do_write && do_read))
    else $error("read and write strobes high in the same cycle");

    // every ODT line is held low while reset is asserted
    reset_quiet: assert property (@(posedge ctl_clk) !ctl_reset_n |-> (afi_odt == '0))
    else $error("ODT driven while reset is asserted");

    // a window, once open, lasts at least the full hold length
    for (genvar i = 0; i < `ODT_CS_WIDTH; i++)
    begin : g_window
        window_length: assert property (
            @(posedge ctl_clk) disable iff (!ctl_reset_n)
            $rose(afi_odt[i]) |-> afi_odt[i] [* `ODT_HOLD_CYCLES])
        else $error("ODT line %0d closed before %0d cycles", i, `ODT_HOLD_CYCLES);
    end

endmodule

bind odt_gen_top odt_gen_checker odt_gen_checker_inst
(
    .ctl_clk     (ctl_clk),
    .ctl_reset_n (ctl_reset_n),
    .do_write    (do_write),
    .do_read     (do_read),
    .afi_odt     (afi_odt)
);

// File: test/odt_gen_tb.sv
/*
 * ODT generator testbench
 * directed tests against a cycle model of the partner map, start delay and hold window
 */
`timescale 1ns/10ps
`include "odt_defs.svh"

module odt_gen_tb;
    import odt_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD = `ODT_HOLD_CYCLES;
    // the number of commands each test issues sizes the watchdog
    localparam int N_WRITE = 5;
    localparam int N_READ = 4;
    localparam int N_LAT = 8;
    localparam int N_PIPE = 40;
    localparam int N_ENABLE = 6;
    localparam int WATCHDOG_CYCLES = (N_WRITE + N_READ + N_LAT + N_PIPE + N_ENABLE) * 20 + 500;

    logic       ctl_clk;
    logic       ctl_reset_n;
    logic       do_write;
    logic       do_read;
    cs_mask_t   to_chip;
    tcl_t       mem_tcl;
    al_t        mem_add_lat;
    logic       odt_enable;
    cs_mask_t   afi_odt;

    int         mismatch_count;
    int         failure_count;
    int         cyc;
    string      test_name;
    logic       rst_cur;
    logic       en_cur;
    tcl_t       tcl_cur;
    al_t        al_cur;
    // the model keeps pending window loads by edge number and one hold counter per chip
    cs_mask_t   sched [int];
    int         remaining [`ODT_CS_WIDTH];

    odt_gen_top odt_gen_top_inst
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .do_write    (do_write),
        .do_read     (do_read),
        .to_chip     (to_chip),
        .mem_tcl     (mem_tcl),
        .mem_add_lat (mem_add_lat),
        .odt_enable  (odt_enable),
        .afi_odt     (afi_odt)
    );

    always #(CLK_PERIOD / 2) ctl_clk = ~ctl_clk;

    // start delay is AL + CL - 3 clamped into the delay line range
    function automatic odt_delay_t expected_delay(input tcl_t tcl, input al_t al);
        int d;
        d = int'(tcl) + int'(al) - 3;
        if (d < 0)
            d = 0;
        if (d > `ODT_MAX_DELAY)
            d = `ODT_MAX_DELAY;
        return odt_delay_t'(d);
    endfunction

    // a write terminates the targets and their partners while a read terminates only partners
    function automatic cs_mask_t term_for(input logic wr, input logic rd, input cs_mask_t chips);
        cs_mask_t mate;
        mate = '0;
        for (int i = 0; i < `ODT_CS_WIDTH; i++)
            mate[i ^ 2] = chips[i];
        if (wr)
            return chips | mate;
        if (rd)
            return mate;
        return '0;
    endfunction

    task automatic check_odt(input string name, input cs_mask_t expected, input cs_mask_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s: afi_odt expected %b, actual %b at cycle %0d",
                     name, expected, actual, cyc);
        end
    endtask

    task automatic check_delay(input string name, input odt_delay_t expected,
                               input odt_delay_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s: start delay expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // each call advances one clock, steps the model, drives the next inputs and then
    // compares after the edge
    task automatic tick(input logic wr, input logic rd, input cs_mask_t chips);
        cs_mask_t expected;
        int       load;
        @(posedge ctl_clk);
        cyc++;
        for (int i = 0; i < `ODT_CS_WIDTH; i++)
        begin
            if (sched.exists(cyc) && sched[cyc][i])
                remaining[i] = HOLD;
            else if (remaining[i] > 0)
                remaining[i]--;
        end
        if (sched.exists(cyc))
            sched.delete(cyc);
        ctl_reset_n <= rst_cur;
        do_write <= wr;
        do_read <= rd;
        to_chip <= chips;
        odt_enable <= en_cur;
        mem_tcl <= tcl_cur;
        mem_add_lat <= al_cur;
        // the command is sampled on the next edge and loads the timer D+2 edges later
        if (rst_cur && en_cur && (wr || rd) && (chips != '0))
        begin
            load = cyc + 3 + int'(expected_delay(tcl_cur, al_cur));
            if (!sched.exists(load))
                sched[load] = '0;
            sched[load] = sched[load] | term_for(wr, rd, chips);
        end
        @(negedge ctl_clk);
        for (int i = 0; i < `ODT_CS_WIDTH; i++)
            expected[i] = (remaining[i] != 0);
        check_odt(test_name, expected, afi_odt);
    endtask

    // issue one command from idle and measure where its window opens
    task automatic issue_and_measure(input logic wr, input logic rd, input cs_mask_t chips);
        odt_delay_t d_exp;
        int         rise_tick;
        d_exp = expected_delay(tcl_cur, al_cur);
        rise_tick = -1;
        tick(wr, rd, chips);
        for (int i = 1; i <= 26; i++)
        begin
            tick(1'b0, 1'b0, '0);
            if ((rise_tick < 0) && (afi_odt != '0))
                rise_tick = i;
        end
        if (rise_tick < 0)
        begin
            failure_count++;
            $display("%s: no ODT window opened after the command", test_name);
        end
        else
            check_delay(test_name, d_exp, odt_delay_t'(rise_tick - 3));
    endtask

    task automatic reset_and_idle();
        test_name = "reset";
        rst_cur = 1'b0;
        repeat (RESET_CYCLES) tick(1'b0, 1'b0, '0);
        rst_cur = 1'b1;
        repeat (10) tick(1'b0, 1'b0, '0);
    endtask

    task automatic write_mapping();
        test_name = "write mapping";
        for (int i = 0; i < 4; i++)
            issue_and_measure(1'b1, 1'b0, cs_mask_t'(1 << i));
        issue_and_measure(1'b1, 1'b0, '1);
    endtask

    task automatic read_mapping();
        test_name = "read mapping";
        for (int i = 0; i < N_READ; i++)
            issue_and_measure(1'b0, 1'b1, cs_mask_t'(1 << i));
    endtask

    // CL 1 with AL 0 clamps to zero and CL 15 with AL 7 clamps high
    // CL 3 with AL 0 and CL 11 with AL 7 sit exactly on the two limits
    task automatic latency_sweep();
        int tcl_list [N_LAT] = '{1, 3, 4, 6, 9, 11, 15, 15};
        int al_list [N_LAT] = '{0, 0, 0, 2, 3, 7, 7, 0};
        for (int n = 0; n < N_LAT; n++)
        begin
            tcl_cur = tcl_t'(tcl_list[n]);
            al_cur = al_t'(al_list[n]);
            test_name = $sformatf("latency tcl=%0d al=%0d", tcl_list[n], al_list[n]);
            repeat (3) tick(1'b0, 1'b0, '0);
            issue_and_measure(1'b1, 1'b0, cs_mask_t'(1));
        end
        tcl_cur = tcl_t'(6);
        al_cur = '0;
        repeat (3) tick(1'b0, 1'b0, '0);
    endtask

    task automatic pipelined_retrigger();
        logic wr;
        test_name = "pipelined retrigger";
        for (int n = 0; n < N_PIPE; n++)
        begin
            wr = 1'($urandom_range(0, 1));
            tick(wr, !wr, cs_mask_t'($urandom));
        end
        // three hits on chip 2 two cycles apart stretch one window
        repeat (3)
        begin
            tick(1'b1, 1'b0, cs_mask_t'(4));
            tick(1'b0, 1'b0, '0);
        end
        repeat (30) tick(1'b0, 1'b0, '0);
    endtask

    task automatic enable_gating();
        test_name = "enable gating";
        // this window is still in the delay line when the enable drops
        tick(1'b1, 1'b0, cs_mask_t'(2));
        tick(1'b0, 1'b0, '0);
        en_cur = 1'b0;
        tick(1'b1, 1'b0, '1);
        tick(1'b0, 1'b1, cs_mask_t'(8));
        tick(1'b1, 1'b0, cs_mask_t'(1));
        repeat (20) tick(1'b0, 1'b0, '0);
        en_cur = 1'b1;
        repeat (2) tick(1'b0, 1'b0, '0);
        issue_and_measure(1'b1, 1'b0, cs_mask_t'(4));
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hd3e1_89fb));
        ctl_clk = 1'b0;
        ctl_reset_n = 1'b0;
        do_write = 1'b0;
        do_read = 1'b0;
        to_chip = '0;
        mem_tcl = tcl_t'(6);
        mem_add_lat = '0;
        odt_enable = 1'b0;
        rst_cur = 1'b0;
        en_cur = 1'b1;
        tcl_cur = tcl_t'(6);
        al_cur = '0;
        cyc = 0;
        mismatch_count = 0;
        failure_count = 0;
        for (int i = 0; i < `ODT_CS_WIDTH; i++)
            remaining[i] = 0;
        reset_and_idle();
        write_mapping();
        read_mapping();
        latency_sweep();
        pipelined_retrigger();
        enable_gating();
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if ((mismatch_count + failure_count) == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: sources.f
+incdir+logic
logic/odt_pkg.sv
logic/odt_ctrl.sv
logic/odt_rank_map.sv
logic/odt_delay_line.sv
logic/odt_hold_timer.sv
logic/odt_gen_top.sv
test/odt_gen_checker.sv
test/odt_gen_tb.sv

// File: Bender.yml
package:
  name: odt_gen

sources:
  - include_dirs:
      - logic
    files:
      - logic/odt_pkg.sv
      - logic/odt_ctrl.sv
      - logic/odt_rank_map.sv
      - logic/odt_delay_line.sv
      - logic/odt_hold_timer.sv
      - logic/odt_gen_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/odt_gen_checker.sv
      - test/odt_gen_tb.sv
